/* sources.f */
+incdir+.
clint_pkg.sv
clint_wb_decode.sv
clint.sv
clint_read_mux.sv
clint_top.sv
tb_clint_top.sv

/* tb_clint_input.txt */
# test op addr data expected, hex fields; data rnd takes the next xorshift value, expected wr is the last write there
# ops W write, R exact read, T mtime read within data cycles of expected or above prev, I wait for irq_timer at expected
1 R 4000 - ffffffff
1 R 4004 - ffffffff
1 R 4008 - ffffffff
1 R 400c - ffffffff
1 R 0000 - 0
1 R 0004 - 0
2 W 0000 rnd -
2 R 0000 - wr
2 W 0004 1 -
2 R 0004 - 1
2 R 0000 - wr
3 W 4004 rnd -
3 W 4008 rnd -
3 W 4000 rnd -
3 W 400c rnd -
3 W 4000 rnd -
3 R 4004 - wr
3 R 4000 - wr
3 R 4008 - wr
3 R 400c - wr
4 W bff8 1000 -
4 T bff8 10 wr
4 T bff8 10 prev
5 I 4008 1e 1
5 W 400c ffffffff -
5 I 4008 - 0
6 R 0008 - 0
6 W 0008 1 -
6 R 0000 - wr
6 W 4010 12345678 -
6 R 4010 - 0
6 R 4008 - wr
6 R bff0 - 0

/* tb_clint_tasks.svh */
// CLINT testbench helpers for Wishbone cycles, xorshift numbers and value checks

`ifndef TB_CLINT_TASKS_SVH
`define TB_CLINT_TASKS_SVH

    task automatic note_error();
        test_err++;
        total_err++;
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
            note_error();
        end
    endtask

    // One classic cycle, request held until ack is seen between edges
    task automatic bus_cycle(input logic we, input adr_t adr, input word_t wdata,
                             output word_t rdata);
        int cnt;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        cnt = 0;
        @(negedge clk);
        while (wb_ack !== 1'b1 && cnt < 20) begin
            @(negedge clk);
            cnt++;
        end
        rdata = wb_dat_r;                              // Valid together with ack
        if (wb_ack !== 1'b1) begin
            $display("No ack for address 0x%h within 20 cycles", adr);
            note_error();
        end
        @(posedge clk);
        wb_cyc <= 1'b0;                                // Release after the ack cycle
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input adr_t adr, input word_t data);
        word_t unused;
        bus_cycle(1'b1, adr, data, unused);
        last_wr[adr] = data;                           // Remembered for later readback
    endtask

    task automatic wb_read(input adr_t adr, output word_t data);
        bus_cycle(1'b0, adr, '0, data);
    endtask

    // 32-bit xorshift step with shifts 13, 17, 5
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

`endif

/* tb_clint_top.sv */
// CLINT testbench replaying Wishbone steps from the stimulus file and checking each response

`timescale 1ns/1ns
`default_nettype none

`include "clint_defs.svh"

module tb_clint_top;

    import clint_pkg::*;

    localparam adr_t MSIP_TOP = adr_t'(`CLINT_MSIP_BASE + `CLINT_MSIP_STRIDE * `CLINT_NUM_CORES);
    localparam adr_t MTIME_LO = adr_t'(`CLINT_MTIME_BASE);
    localparam adr_t MTIME_HI = adr_t'(`CLINT_MTIME_BASE + 4);

    logic clk;
    logic rst;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    adr_t wb_adr;
    word_t wb_dat_w;
    word_t wb_dat_r;
    logic wb_ack;
    logic [`CLINT_NUM_CORES-1:0] irq_timer;
    logic [`CLINT_NUM_CORES-1:0] irq_soft;

    word_t last_wr [0:65535];                          // Last value written per byte address
    logic [31:0] rng_state;
    int test_err;                                      // Errors in the running test
    int total_err;
    int tests_passed;
    int tests_failed;

    clint_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .irq_timer (irq_timer),
        .irq_soft  (irq_soft)
    );

    always #20 clk = ~clk;                             // 40 ns period

    `include "tb_clint_tasks.svh"

    // Decodes a data or expected token given as hex, rnd, wr, or a dash for zero
    function automatic word_t token_value(input logic [63:0] tok, input adr_t adr);
        word_t v;
        v = '0;
        if (tok == "rnd") begin
            rng_state = xorshift(rng_state);
            v = rng_state;
        end else if (tok == "wr") begin
            v = (adr < MSIP_TOP) ? (last_wr[adr] & 32'h1) : last_wr[adr];  // msip holds bit 0
        end else if (tok != "-") begin
            void'($sscanf(tok, "%h", v));
        end
        return v;
    endfunction

    task automatic finish_test(input int num);
        if (test_err == 0) begin
            $display("Test %0d passed", num);
            tests_passed++;
        end else begin
            $display("Test %0d failed with %0d errors", num, test_err);
            tests_failed++;
        end
        test_err = 0;
    endtask

    initial begin
        int fd;
        int n;
        int tnum;
        int cur_test;
        int cnt;
        int h;
        logic [8*128-1:0] line;
        logic [7:0] op;
        adr_t adr;
        logic [63:0] dtok;
        logic [63:0] etok;
        word_t data;
        word_t exp;
        word_t got;
        word_t hi;
        word_t prev_t;
        logic [63:0] cmp;
        clk = 1'b0;
        rst = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        rng_state = 32'd95522;
        test_err = 0;
        total_err = 0;
        tests_passed = 0;
        tests_failed = 0;
        cur_test = 0;
        prev_t = '0;
        cmp = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("irq_timer", irq_timer, '0);       // Counted against the first test
        check_value("irq_soft", irq_soft, '0);
        fd = $fopen("tb_clint_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file tb_clint_input.txt");
            total_err++;
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                n = $fgets(line, fd);
                n = $sscanf(line, "%d %s %h %s %s", tnum, op, adr, dtok, etok);
                if (n == 5) begin                      // Comments and blank lines skipped
                    if (cur_test != 0 && tnum != cur_test) finish_test(cur_test);
                    cur_test = tnum;
                    data = token_value(dtok, adr);
                    case (op)
                        "W": wb_write(adr, data);
                        "R": begin
                            exp = token_value(etok, adr);
                            wb_read(adr, got);
                            check_value("wb_dat_r", got, exp);
                            if (adr < MSIP_TOP) begin
                                @(negedge clk);        // Interrupt sampled between edges
                                check_value("irq_soft", irq_soft[adr >> 2], exp[0]);
                            end
                        end
                        "T": begin                     // Counter keeps running during the read
                            exp = (etok == "prev") ? prev_t + 1 : token_value(etok, adr);
                            wb_read(adr, got);
                            if (got < exp || got > exp + data) begin
                                $display("Error: mtime is 0x%h, expected 0x%h to 0x%h",
                                         got, exp, exp + data);
                                note_error();
                            end
                            prev_t = got;
                        end
                        "I": begin
                            h = int'((adr - adr_t'(`CLINT_MTIMECMP_BASE)) >> 3);
                            exp = token_value(etok, adr);
                            if (exp[0]) begin          // Arm compare at mtime plus offset
                                wb_read(MTIME_LO, got);
                                wb_read(MTIME_HI, hi);
                                cmp = {hi, got} + {32'd0, data};
                                wb_write(adr_t'(adr + 4), cmp[63:32]);  // Upper first
                                wb_write(adr, cmp[31:0]);
                            end
                            cnt = 0;
                            @(negedge clk);
                            while (irq_timer[h] !== exp[0] && cnt < 200) begin
                                @(negedge clk);
                                cnt++;
                            end
                            if (irq_timer[h] !== exp[0]) begin
                                $display("irq_timer of hart %0d did not reach %0d in time",
                                         h, exp[0]);
                                note_error();
                            end else if (exp[0]) begin
                                wb_read(MTIME_LO, got);
                                wb_read(MTIME_HI, hi);
                                if ({hi, got} < cmp) begin
                                    $display("Error: mtime is 0x%h, below mtimecmp 0x%h",
                                             {hi, got}, cmp);
                                    note_error();
                                end
                            end
                        end
                        default: begin
                            $display("Unknown operation %s in test %0d", op, tnum);
                            note_error();
                        end
                    endcase
                end
            end
            if (cur_test != 0) finish_test(cur_test);
            $fclose(fd);
        end
        $display("Tests passed: %0d, failed: %0d, errors: %0d",
                 tests_passed, tests_failed, total_err);
        if (total_err == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* clint_top.sv */
// CLINT top level joining the Wishbone decoder, timer block and read path

`timescale 1ns/1ns
`default_nettype none

`include "clint_defs.svh"

module clint_top (
    input  logic                         clk,
    input  logic                         rst,

    // Wishbone classic slave
    input  logic                         wb_cyc,
    input  logic                         wb_stb,
    input  logic                         wb_we,
    input  clint_pkg::adr_t              wb_adr,
    input  clint_pkg::word_t             wb_dat_w,
    output clint_pkg::word_t             wb_dat_r,
    output logic                         wb_ack,

    // Per-hart interrupt lines
    output logic [`CLINT_NUM_CORES-1:0]  irq_timer,
    output logic [`CLINT_NUM_CORES-1:0]  irq_soft
);

    import clint_pkg::*;

    logic       write_mtime;
    logic       write_mtimecmp;
    logic       write_msip;
    logic       write_upper;
    core_idx_t  write_msip_core;
    core_idx_t  write_mtimecmp_core;
    word_t      write_data;

    reg_sel_t   rd_sel;
    core_idx_t  rd_core;
    logic       rd_upper;
    logic       rd_en;

    word_t [1:0]                        mtime;
    word_t [`CLINT_NUM_CORES-1:0][1:0]  mtimecmp;
    logic  [`CLINT_NUM_CORES-1:0]       msip;
    logic  [`CLINT_NUM_CORES-1:0]       mtip;

    clint_wb_decode decode_i (
        .clk                 (clk),
        .rst                 (rst),
        .wb_cyc              (wb_cyc),
        .wb_stb              (wb_stb),
        .wb_we               (wb_we),
        .wb_adr              (wb_adr),
        .wb_dat_w            (wb_dat_w),
        .wb_ack              (wb_ack),
        .write_mtime         (write_mtime),
        .write_mtimecmp      (write_mtimecmp),
        .write_msip          (write_msip),
        .write_upper         (write_upper),
        .write_msip_core     (write_msip_core),
        .write_mtimecmp_core (write_mtimecmp_core),
        .write_data          (write_data),
        .rd_sel              (rd_sel),
        .rd_core             (rd_core),
        .rd_upper            (rd_upper),
        .rd_en               (rd_en)
    );

    clint #(.NUM_CORES(`CLINT_NUM_CORES)) clint_i (
        .clk                 (clk),
        .rst                 (rst),
        .write_mtime         (write_mtime),
        .write_mtimecmp      (write_mtimecmp),
        .write_msip          (write_msip),
        .write_upper         (write_upper),
        .write_msip_core     (write_msip_core),
        .write_mtimecmp_core (write_mtimecmp_core),
        .write_data          (write_data),
        .mtime               (mtime),
        .mtimecmp            (mtimecmp),
        .msip                (msip),
        .mtip                (mtip)
    );

    clint_read_mux #(.NUM_CORES(`CLINT_NUM_CORES)) read_mux_i (
        .clk      (clk),
        .rst      (rst),
        .rd_en    (rd_en),
        .rd_sel   (rd_sel),
        .rd_core  (rd_core),
        .rd_upper (rd_upper),
        .mtime    (mtime),
        .mtimecmp (mtimecmp),
        .msip     (msip),
        .wb_dat_r (wb_dat_r)
    );

    assign irq_timer = mtip;                           // Straight from the compare flops
    assign irq_soft  = msip;

endmodule

`default_nettype wire

/* clint_read_mux.sv */
// CLINT read path selecting the addressed register word and holding it for the bus

`timescale 1ns/1ns
`default_nettype none

`include "clint_defs.svh"

module clint_read_mux #(
    parameter int unsigned NUM_CORES = `CLINT_NUM_CORES
) (
    input  logic                                              clk,
    input  logic                                              rst,

    input  logic                                              rd_en,
    input  clint_pkg::reg_sel_t                               rd_sel,
    input  logic [((NUM_CORES > 1) ? $clog2(NUM_CORES) : 1)-1:0] rd_core,
    input  logic                                              rd_upper,

    input  clint_pkg::word_t [1:0]                            mtime,
    input  clint_pkg::word_t [NUM_CORES-1:0][1:0]             mtimecmp,
    input  logic [NUM_CORES-1:0]                              msip,

    output clint_pkg::word_t                                  wb_dat_r
);

    import clint_pkg::*;

    word_t rd_word;

    // Decoder maps harts out of range to SEL_NONE
    always_comb begin
        rd_word = '0;
        case (rd_sel)
            SEL_MSIP:     rd_word = {31'd0, msip[rd_core]};   // Zero-extended bit
            SEL_MTIMECMP: rd_word = mtimecmp[rd_core][rd_upper];
            SEL_MTIME:    rd_word = mtime[rd_upper];          // Value before the ack edge
            default:      rd_word = '0;                       // Unmapped reads as zero
        endcase
    end

    // Output register holds between reads
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_dat_r <= '0;
        end else if (rd_en) begin
            wb_dat_r <= rd_word;
        end
    end

endmodule

`default_nettype wire

/* clint.sv */
// CLINT timer block with free-running mtime, per-hart mtimecmp and msip, and registered mtip

`timescale 1ns/1ns
`default_nettype none

`include "clint_defs.svh"

module clint #(
    parameter int unsigned NUM_CORES = `CLINT_NUM_CORES
) (
    input  logic                                              clk,
    input  logic                                              rst,

    input  logic                                              write_mtime,
    input  logic                                              write_mtimecmp,
    input  logic                                              write_msip,
    input  logic                                              write_upper,
    input  logic [((NUM_CORES > 1) ? $clog2(NUM_CORES) : 1)-1:0] write_msip_core,
    input  logic [((NUM_CORES > 1) ? $clog2(NUM_CORES) : 1)-1:0] write_mtimecmp_core,
    input  clint_pkg::word_t                                  write_data,

    output clint_pkg::word_t [1:0]                            mtime,    // [1] upper word
    output clint_pkg::word_t [NUM_CORES-1:0][1:0]             mtimecmp,
    output logic [NUM_CORES-1:0]                              msip,
    output logic [NUM_CORES-1:0]                              mtip
);

    import clint_pkg::*;

    logic [63:0] mtime_cur;
    logic [63:0] mtime_inc;
    word_t       mtime_hi_next;
    word_t       mtime_lo_next;

    assign mtime_cur = {mtime[1], mtime[0]};
    assign mtime_inc = mtime_cur + 64'd1;

    // A write replaces only its own half, the other half keeps counting
    assign mtime_hi_next = (write_mtime && write_upper)  ? write_data : mtime_inc[63:32];
    assign mtime_lo_next = (write_mtime && !write_upper) ? write_data : mtime_inc[31:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            mtime    <= '0;
            mtimecmp <= '1;                            // Max compare keeps mtip quiet
            msip     <= '0;
            mtip     <= '0;
        end else begin
            mtime[1] <= mtime_hi_next;
            mtime[0] <= mtime_lo_next;
            for (int i = 0; i < NUM_CORES; i++) begin
                if (write_mtimecmp && (i == int'(write_mtimecmp_core))) begin
                    mtimecmp[i][write_upper] <= write_data;
                end
                if (write_msip && (i == int'(write_msip_core))) begin
                    msip[i] <= write_data[0];          // Only bit 0 is implemented
                end
                // Unsigned 64-bit compare, lags mtime and mtimecmp by one cycle
                mtip[i] <= (mtime_cur >= {mtimecmp[i][1], mtimecmp[i][0]});
            end
        end
    end

    // Counter steps by one whenever the bus leaves it alone
    mtime_counts: assert property (@(posedge clk) disable iff (rst)
        (!$past(rst) && !$past(write_mtime)) |-> (mtime_cur == $past(mtime_cur) + 64'd1));

endmodule

`default_nettype wire

/* clint_wb_decode.sv */
// CLINT Wishbone classic front end decoding addresses into write strobes and read selects

`timescale 1ns/1ns
`default_nettype none

`include "clint_defs.svh"

module clint_wb_decode (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  clint_pkg::adr_t       wb_adr,
    input  clint_pkg::word_t      wb_dat_w,
    output logic                  wb_ack,

    output logic                  write_mtime,
    output logic                  write_mtimecmp,
    output logic                  write_msip,
    output logic                  write_upper,         // Upper word of a 64-bit register
    output clint_pkg::core_idx_t  write_msip_core,
    output clint_pkg::core_idx_t  write_mtimecmp_core,
    output clint_pkg::word_t      write_data,

    output clint_pkg::reg_sel_t   rd_sel,
    output clint_pkg::core_idx_t  rd_core,
    output logic                  rd_upper,
    output logic                  rd_en                // Loads the read register
);

    import clint_pkg::*;

    // Size of each hart window, offsets at or above these are unmapped
    localparam adr_t MSIP_SPAN  = adr_t'(`CLINT_MSIP_STRIDE * `CLINT_NUM_CORES);
    localparam adr_t CMP_SPAN   = adr_t'(`CLINT_MTIMECMP_STRIDE * `CLINT_NUM_CORES);
    localparam adr_t MTIME_SPAN = adr_t'(8);

    bus_state_t state;
    bus_state_t state_next;

    adr_t       msip_off;
    adr_t       cmp_off;
    adr_t       mtime_off;
    core_idx_t  msip_core;
    core_idx_t  cmp_core;

    reg_sel_t   dec_sel;
    core_idx_t  dec_core;
    logic       dec_upper;
    logic       req;                                   // Request accepted this cycle

    // Offsets wrap below the base, so one unsigned compare bounds each window
    assign msip_off  = wb_adr - adr_t'(`CLINT_MSIP_BASE);
    assign cmp_off   = wb_adr - adr_t'(`CLINT_MTIMECMP_BASE);
    assign mtime_off = wb_adr - adr_t'(`CLINT_MTIME_BASE);

    assign msip_core = core_idx_t'(msip_off / `CLINT_MSIP_STRIDE);
    assign cmp_core  = core_idx_t'(cmp_off / `CLINT_MTIMECMP_STRIDE);

    always_comb begin
        dec_sel   = SEL_NONE;                          // Default reads 0, writes dropped
        dec_core  = '0;
        dec_upper = 1'b0;
        if (msip_off < MSIP_SPAN) begin
            dec_sel  = SEL_MSIP;
            dec_core = msip_core;
        end else if (cmp_off < CMP_SPAN) begin
            dec_sel   = SEL_MTIMECMP;
            dec_core  = cmp_core;
            dec_upper = cmp_off[2];                    // Second word of the doubleword
        end else if (mtime_off < MTIME_SPAN) begin
            dec_sel   = SEL_MTIME;
            dec_upper = mtime_off[2];
        end
    end

    // Two-state handshake, one ack per request then back to idle
    always_comb begin
        state_next = state;
        case (state)
            BUS_IDLE: if (wb_cyc && wb_stb) state_next = BUS_ACK;
            BUS_ACK:  state_next = BUS_IDLE;           // Master drops stb or starts anew
            default:  state_next = BUS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= BUS_IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign req    = wb_cyc && wb_stb && (state == BUS_IDLE);
    assign wb_ack = (state == BUS_ACK);                // Registered, one cycle after req

    // Strobes fire in the idle cycle so registers update on the ack edge
    assign write_msip          = req && wb_we && (dec_sel == SEL_MSIP);
    assign write_mtimecmp      = req && wb_we && (dec_sel == SEL_MTIMECMP);
    assign write_mtime         = req && wb_we && (dec_sel == SEL_MTIME);
    assign write_upper         = dec_upper;
    assign write_msip_core     = dec_core;
    assign write_mtimecmp_core = dec_core;
    assign write_data          = wb_dat_w;

    // Read word is captured on the same edge, valid alongside ack
    assign rd_en    = req && !wb_we;
    assign rd_sel   = dec_sel;
    assign rd_core  = dec_core;
    assign rd_upper = dec_upper;

    // Each accepted request produces a single ack pulse
    ack_single_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack);

    // Decoded regions never overlap
    strobe_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({write_mtime, write_mtimecmp, write_msip}));

endmodule

`default_nettype wire

/* clint_pkg.sv */
// CLINT shared types for bus words, addresses, hart indices and register selection

`default_nettype none

`include "clint_defs.svh"

package clint_pkg;

    // Hart index needs at least one bit even with a single hart
    localparam int unsigned CORE_IDX_W =
        (`CLINT_NUM_CORES > 1) ? $clog2(`CLINT_NUM_CORES) : 1;

    typedef logic [31:0] word_t;                     // One bus word
    typedef logic [`CLINT_ADR_W-1:0] adr_t;           // Byte address on the bus
    typedef logic [CORE_IDX_W-1:0] core_idx_t;        // Hart number

    // Register targeted by the current bus transaction
    typedef enum logic [1:0] {
        SEL_NONE,                                    // Unmapped or hart out of range
        SEL_MSIP,
        SEL_MTIMECMP,
        SEL_MTIME
    } reg_sel_t;

    // Wishbone slave handshake states
    typedef enum logic {
        BUS_IDLE,                                    // Waiting for cyc and stb
        BUS_ACK                                      // Ack driven this cycle
    } bus_state_t;

endpackage

`default_nettype wire

/* clint_defs.svh */
// CLINT build constants covering hart count, bus address width and register map offsets

`ifndef CLINT_DEFS_SVH
`define CLINT_DEFS_SVH

// Number of harts served by this interruptor
`define CLINT_NUM_CORES 2

// Byte address width seen on the Wishbone port
`define CLINT_ADR_W 16

// Software interrupt words, one 32-bit word per hart
`define CLINT_MSIP_BASE 'h0000
`define CLINT_MSIP_STRIDE 4

// Timer compare registers, one 64-bit doubleword per hart
`define CLINT_MTIMECMP_BASE 'h4000
`define CLINT_MTIMECMP_STRIDE 8

// Machine timer doubleword, lower word first
`define CLINT_MTIME_BASE 'hBFF8

// Upper half of any 64-bit register sits at base plus 4
// Everything outside these windows reads as zero

`endif
